//--- logic/mdPkg.sv
//////////////////////////////////////////////////////////////////////
// Multiply/divide unit shared definitions
// Operation codes follow the RISC-V M-extension funct3 field
//////////////////////////////////////////////////////////////////////

`default_nettype none

package mdPkg;

   // Default operand and result width
   localparam int mdDefaultWidth = 32;

   // M-extension operations, encoded as funct3
   // Bit 2 set selects the divider
   typedef enum logic [2:0] {
      opMul    = 3'b000,  // Low half, sign does not matter
      opMulh   = 3'b001,  // High half, signed x signed
      opMulhsu = 3'b010,  // High half, signed x unsigned
      opMulhu  = 3'b011,  // High half, unsigned x unsigned
      opDiv    = 3'b100,  // Signed quotient
      opDivu   = 3'b101,  // Unsigned quotient
      opRem    = 3'b110,  // Signed remainder
      opRemu   = 3'b111   // Unsigned remainder
   } mdOp_t;

   // Quotient and remainder round toward zero
   // Remainder takes the sign of the dividend
   // Divide by zero
   //    quotient is all ones
   //    remainder is the dividend
   // Most negative divided by minus one
   //    quotient is the most negative value
   //    remainder is zero

endpackage

`default_nettype wire

//--- logic/mdRequestStage.sv
//////////////////////////////////////////////////////////////////////
// Request stage of the multiply/divide unit
// Holds one request, decodes funct3 and issues it to a unit
// once both execution units are idle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mdRequestStage #(
   parameter int width = mdPkg::mdDefaultWidth
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             reqValid,
   input  mdPkg::mdOp_t     reqOp,
   input  logic [width-1:0] reqA,
   input  logic [width-1:0] reqB,
   output logic             reqReady,
   input  logic             mulBusy,
   input  logic             divBusy,
   output logic             mulStart,
   output logic             mulSignA,
   output logic             mulSignB,
   output logic             mulHigh,
   output logic             divStart,
   output logic             divSigned,
   output logic             divRem,
   output logic [width-1:0] opA,
   output logic [width-1:0] opB
);
   import mdPkg::*;

   logic             entryValid;  // One-entry holding register
   mdOp_t            entryOp;
   logic [width-1:0] entryA;
   logic [width-1:0] entryB;
   logic             issue;

   // Only one operation in the units at a time, keeps results in order
   assign issue    = entryValid & ~mulBusy & ~divBusy;
   assign reqReady = ~entryValid | issue;  // Empty, or emptied this cycle

   always_ff @(posedge clk) begin
      if (!reset) begin
         entryValid <= 1'b0;
         mulStart   <= 1'b0;
         divStart   <= 1'b0;
      end else begin
         if (reqValid && reqReady)
            entryValid <= 1'b1;
         else if (issue)
            entryValid <= 1'b0;
         mulStart <= issue & ~entryOp[2];  // Single-cycle pulses
         divStart <= issue &  entryOp[2];
      end
   end

   // Request payload
   always_ff @(posedge clk) begin
      if (reqValid && reqReady) begin
         entryOp <= reqOp;
         entryA  <= reqA;
         entryB  <= reqB;
      end
   end

   // Operands and control bits go out with the start pulse
   always_ff @(posedge clk) begin
      if (issue) begin
         opA       <= entryA;
         opB       <= entryB;
         mulSignA  <= (entryOp == opMulh) || (entryOp == opMulhsu);
         mulSignB  <= (entryOp == opMulh);
         mulHigh   <= (entryOp != opMul);
         divSigned <= (entryOp == opDiv) || (entryOp == opRem);
         divRem    <= (entryOp == opRem) || (entryOp == opRemu);
      end
   end

endmodule

`default_nettype wire

//--- logic/mdMultiplier.sv
//////////////////////////////////////////////////////////////////////
// Registered multiplier for MUL, MULH, MULHSU and MULHU
// One signed multiply one bit wider than the operands
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mdMultiplier #(
   parameter int width = mdPkg::mdDefaultWidth
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             mulStart,
   input  logic             mulSignA,
   input  logic             mulSignB,
   input  logic             mulHigh,
   input  logic [width-1:0] opA,
   input  logic [width-1:0] opB,
   input  logic             mulTake,
   output logic             busy,
   output logic             done,
   output logic [width-1:0] result
);

   logic signed [width:0]     extA;     // Sign or zero extended
   logic signed [width:0]     extB;
   logic        [2*width-1:0] product;  // Low 2*width bits are exact

   assign extA    = {mulSignA & opA[width-1], opA};
   assign extB    = {mulSignB & opB[width-1], opB};
   assign product = extA * extB;

   assign busy = mulStart | done;  // Covers the issue cycle too

   always_ff @(posedge clk) begin
      if (!reset) begin
         done <= 1'b0;
      end else begin
         if (mulStart)
            done <= 1'b1;
         else if (mulTake)
            done <= 1'b0;  // Response stage has the result
      end
   end

   // Held until taken
   always_ff @(posedge clk) begin
      if (mulStart)
         result <= mulHigh ? product[2*width-1:width] : product[width-1:0];
   end

endmodule

`default_nettype wire

//--- logic/mdDivider.sv
//////////////////////////////////////////////////////////////////////
// Serial restoring divider for DIV, DIVU, REM and REMU
// Works on magnitudes, one quotient bit per cycle, and
// applies the sign to the chosen result in the last step
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mdDivider #(
   parameter int width = mdPkg::mdDefaultWidth
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             divStart,
   input  logic             divSigned,
   input  logic             divRem,
   input  logic [width-1:0] opA,
   input  logic [width-1:0] opB,
   input  logic             divTake,
   output logic             busy,
   output logic             done,
   output logic [width-1:0] result
);

   localparam int cntWidth = $clog2(width + 1);

   logic [cntWidth-1:0] count;       // Iterations left
   logic [width-1:0]    dividend;    // Partial remainder
   logic [2*width-2:0]  divisor;     // Walks down one bit per step
   logic [width-1:0]    quotient;
   logic                resultSign;  // Negate at the end
   logic                wantRem;     // Remainder instead of quotient
   logic [width-1:0]    magA;
   logic [width-1:0]    magB;
   logic                fits;
   logic [width-1:0]    remNext;
   logic [width-1:0]    quoNext;
   logic [width-1:0]    chosen;

   // Most negative value keeps its pattern, which is its magnitude
   assign magA = (divSigned && opA[width-1]) ? -opA : opA;
   assign magB = (divSigned && opB[width-1]) ? -opB : opB;

   // One compare-subtract step
   assign fits    = divisor <= {{(width-1){1'b0}}, dividend};
   assign remNext = fits ? dividend - divisor[width-1:0] : dividend;
   assign quoNext = {quotient[width-2:0], fits};
   assign chosen  = wantRem ? remNext : quoNext;

   assign busy = divStart | (count != '0) | done;

   always_ff @(posedge clk) begin
      if (!reset) begin
         count <= '0;
         done  <= 1'b0;
      end else begin
         if (divStart)
            count <= cntWidth'(width);  // Set-up cycle loads the counter
         else if (count != '0)
            count <= count - 1'b1;
         if (count == cntWidth'(1))
            done <= 1'b1;               // Last step writes the result
         else if (divTake)
            done <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (divStart) begin
         dividend <= magA;
         divisor  <= {magB, {(width-1){1'b0}}};
         quotient <= '0;
         wantRem  <= divRem;
         // Remainder follows the dividend
         // Quotient is negative only when signs differ and divisor is non-zero
         // so divide by zero stays all ones
         if (divRem)
            resultSign <= divSigned & opA[width-1];
         else
            resultSign <= divSigned & (opA[width-1] ^ opB[width-1]) & (|opB);
      end else if (count != '0) begin
         dividend <= remNext;
         divisor  <= divisor >> 1;
         quotient <= quoNext;
         if (count == cntWidth'(1))
            result <= resultSign ? -chosen : chosen;  // Sign fix folded in
      end
   end

endmodule

`default_nettype wire

//--- logic/mdResponseStage.sv
//////////////////////////////////////////////////////////////////////
// Response stage of the multiply/divide unit
// One-entry output register fed by whichever unit is done
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mdResponseStage #(
   parameter int width = mdPkg::mdDefaultWidth
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             mulDone,
   input  logic [width-1:0] mulResult,
   input  logic             divDone,
   input  logic [width-1:0] divResult,
   output logic             mulTake,
   output logic             divTake,
   output logic             rspValid,
   input  logic             rspReady,
   output logic [width-1:0] rspData
);

   logic canLoad;  // Register empty or being read

   assign canLoad = ~rspValid | rspReady;

   // At most one unit holds a result, so the priority never matters
   assign mulTake = canLoad & mulDone;
   assign divTake = canLoad & ~mulDone & divDone;

   always_ff @(posedge clk) begin
      if (!reset) begin
         rspValid <= 1'b0;
      end else begin
         if (mulTake || divTake)
            rspValid <= 1'b1;
         else if (rspReady)
            rspValid <= 1'b0;  // Drained, nothing new
      end
   end

   // Loads only when free, so data is stable under back-pressure
   always_ff @(posedge clk) begin
      if (mulTake)
         rspData <= mulResult;
      else if (divTake)
         rspData <= divResult;
   end

endmodule

`default_nettype wire

//--- logic/mdUnit.sv
//////////////////////////////////////////////////////////////////////
// M-extension multiply/divide unit
// Valid/ready request and response channels around a multiplier
// and a serial divider, results returned in request order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mdUnit #(
   parameter int width = mdPkg::mdDefaultWidth  // Any even width from 8 up
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             reqValid,
   output logic             reqReady,
   input  mdPkg::mdOp_t     reqOp,
   input  logic [width-1:0] reqA,
   input  logic [width-1:0] reqB,
   output logic             rspValid,
   input  logic             rspReady,
   output logic [width-1:0] rspData
);

   logic             mulStart;
   logic             mulSignA;
   logic             mulSignB;
   logic             mulHigh;
   logic             divStart;
   logic             divSigned;
   logic             divRem;
   logic [width-1:0] opA;        // Shared by both units
   logic [width-1:0] opB;
   logic             mulBusy;
   logic             mulDone;
   logic [width-1:0] mulResult;
   logic             mulTake;
   logic             divBusy;
   logic             divDone;
   logic [width-1:0] divResult;
   logic             divTake;

   mdRequestStage #(.width(width)) requestStage (
      .clk, .reset,
      .reqValid, .reqOp, .reqA, .reqB, .reqReady,
      .mulBusy, .divBusy,
      .mulStart, .mulSignA, .mulSignB, .mulHigh,
      .divStart, .divSigned, .divRem,
      .opA, .opB
   );

   mdMultiplier #(.width(width)) multiplier (
      .clk, .reset,
      .mulStart, .mulSignA, .mulSignB, .mulHigh,
      .opA, .opB, .mulTake,
      .busy(mulBusy), .done(mulDone), .result(mulResult)
   );

   mdDivider #(.width(width)) divider (
      .clk, .reset,
      .divStart, .divSigned, .divRem,
      .opA, .opB, .divTake,
      .busy(divBusy), .done(divDone), .result(divResult)
   );

   mdResponseStage #(.width(width)) responseStage (
      .clk, .reset,
      .mulDone, .mulResult, .divDone, .divResult,
      .mulTake, .divTake,
      .rspValid, .rspReady, .rspData
   );

endmodule

`default_nettype wire

//--- tb/mdUnit_props.sv
//////////////////////////////////////////////////////////////////////
// Handshake properties of the multiply/divide unit
// Bound to the top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mdUnitProps #(
   parameter int width = mdPkg::mdDefaultWidth
) (
   input logic             clk,
   input logic             reset,
   input logic             reqReady,
   input logic             rspValid,
   input logic             rspReady,
   input logic [width-1:0] rspData
);

   // Response held while the sink stalls
   rspHeld: assert property (@(posedge clk) disable iff (!reset)
      rspValid && !rspReady |=> rspValid && $stable(rspData))
      else $error("response changed or dropped under back-pressure");

   // Idle state once reset has been applied
   resetState: assert property (@(posedge clk)
      !reset |=> reqReady && !rspValid)
      else $error("unit not idle in the cycle after reset");

endmodule

bind mdUnit mdUnitProps #(.width(width)) props (
   .clk(clk),
   .reset(reset),
   .reqReady(reqReady),
   .rspValid(rspValid),
   .rspReady(rspReady),
   .rspData(rspData)
);

`default_nettype wire

//--- tb/mdUnitTb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the multiply/divide unit
// Table of operations with known results, random gaps and
// random response back-pressure, results checked in order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mdUnitTb;
   import mdPkg::*;

   localparam int width         = mdDefaultWidth;
   localparam int numVectors    = 25;
   localparam int timeoutCycles = numVectors * (width + 3) * 4;  // Worst divide, slack x4

   logic             clk;
   logic             reset;
   logic             reqValid;
   logic             reqReady;
   mdOp_t            reqOp;
   logic [width-1:0] reqA;
   logic [width-1:0] reqB;
   logic             rspValid;
   logic             rspReady;
   logic [width-1:0] rspData;

   string            vecName     [numVectors];
   mdOp_t            vecOp       [numVectors];
   logic [width-1:0] vecA        [numVectors];
   logic [width-1:0] vecB        [numVectors];
   logic [width-1:0] vecExpected [numVectors];
   int               vecCount;
   int               cycleCount;

   mdUnit #(.width(width)) dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;  // 100 ns period
   end

   task automatic failRun(input string reason);
      $display("%s", reason);
      $display("Regression failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic addVector(input string name, input mdOp_t op,
                            input logic [width-1:0] a, b, expected);
      vecName[vecCount]     = name;
      vecOp[vecCount]       = op;
      vecA[vecCount]        = a;
      vecB[vecCount]        = b;
      vecExpected[vecCount] = expected;
      vecCount++;
   endtask

   // Multiplies and divides interleaved to exercise ordering
   task automatic loadTable();
      vecCount = 0;
      addVector("mulSmall",      opMul,    32'h00000007, 32'h00000006, 32'h0000002A);
      addVector("divPos",        opDiv,    32'h00000064, 32'h00000007, 32'h0000000E);
      addVector("mulNeg",        opMul,    32'hFFFFFFFD, 32'h00000005, 32'hFFFFFFF1);
      addVector("divNegA",       opDiv,    32'hFFFFFF9C, 32'h00000007, 32'hFFFFFFF2);
      addVector("mulhNeg",       opMulh,   32'hFFFFFFFD, 32'h00000005, 32'hFFFFFFFF);
      addVector("remNegA",       opRem,    32'hFFFFFF9C, 32'h00000007, 32'hFFFFFFFE);
      addVector("mulhuOnes",     opMulhu,  32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFE);
      addVector("remNegB",       opRem,    32'h00000064, 32'hFFFFFFF9, 32'h00000002);
      addVector("mulhMinMin",    opMulh,   32'h80000000, 32'h80000000, 32'h40000000);
      addVector("divNegB",       opDiv,    32'h00000064, 32'hFFFFFFF9, 32'hFFFFFFF2);
      addVector("mulhsuNegOnes", opMulhsu, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFF);
      addVector("divNegBoth",    opDiv,    32'hFFFFFF9C, 32'hFFFFFFF9, 32'h0000000E);
      addVector("mulhsuMax",     opMulhsu, 32'h7FFFFFFF, 32'hFFFFFFFF, 32'h7FFFFFFE);
      addVector("remNegBoth",    opRem,    32'hFFFFFF9C, 32'hFFFFFFF9, 32'hFFFFFFFE);
      addVector("mulMinOnes",    opMul,    32'h80000000, 32'hFFFFFFFF, 32'h80000000);
      addVector("divuBig",       opDivu,   32'hFFFFFF9C, 32'h00000007, 32'h24924916);
      addVector("mulhuCarry",    opMulhu,  32'h80000000, 32'h00000002, 32'h00000001);
      addVector("remuBig",       opRemu,   32'hFFFFFF9C, 32'h00000007, 32'h00000002);
      addVector("mulhPos",       opMulh,   32'h12345678, 32'h00000010, 32'h00000001);
      addVector("divZero",       opDiv,    32'h00001234, 32'h00000000, 32'hFFFFFFFF);
      addVector("divuZero",      opDivu,   32'h00001234, 32'h00000000, 32'hFFFFFFFF);
      addVector("remZero",       opRem,    32'hFFFFFF9C, 32'h00000000, 32'hFFFFFF9C);
      addVector("remuZero",      opRemu,   32'h00001234, 32'h00000000, 32'h00001234);
      addVector("divOverflow",   opDiv,    32'h80000000, 32'hFFFFFFFF, 32'h80000000);
      addVector("remOverflow",   opRem,    32'h80000000, 32'hFFFFFFFF, 32'h00000000);
      assert (vecCount == numVectors)
         else failRun("stimulus table length does not match its declared size");
   endtask

   // Request side, 0 to 2 idle cycles between requests
   task automatic driveRequests();
      int gap;
      bit accepted;
      for (int i = 0; i < numVectors; i++) begin
         gap      = $urandom % 3;
         reqValid = 1'b0;
         repeat (gap) @(negedge clk);
         reqValid = 1'b1;
         reqOp    = vecOp[i];
         reqA     = vecA[i];
         reqB     = vecB[i];
         if (i == 0)
            assert (reqReady) else failRun("first request after reset was not accepted");
         accepted = 1'b0;
         while (!accepted) begin
            accepted = reqReady;  // Registered, steady between edges
            @(negedge clk);
         end
      end
      reqValid = 1'b0;
   endtask

   // Response side with random stalls, checks in request order
   task automatic collectResponses();
      int rspCount;
      rspCount = 0;
      while (rspCount < numVectors) begin
         @(negedge clk);
         rspReady = ($urandom % 4) != 0;  // Ready three cycles in four
         if (rspValid && rspReady) begin
            assert (rspData === vecExpected[rspCount])
               else failRun($sformatf("Mismatch in %s: expected %h, actual %h",
                                      vecName[rspCount], vecExpected[rspCount], rspData));
            rspCount++;
         end
      end
   endtask

   initial begin
      cycleCount = 0;
      while (cycleCount < timeoutCycles) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Timeout: the unit stopped responding after %0d cycles", cycleCount);
      $display("Regression failed");
      $fatal(1, "simulation limit reached");
   end

   initial begin
      void'($urandom(32'h8ad3));
      reset    = 1'b0;
      reqValid = 1'b0;
      reqOp    = opMul;
      reqA     = '0;
      reqB     = '0;
      rspReady = 1'b0;
      loadTable();
      repeat (10) @(negedge clk);  // Ten reset edges
      reset = 1'b1;
      assert (reqReady && !rspValid) else failRun("DUT not idle after reset");
      fork
         driveRequests();
         collectResponses();
      join
      // Nothing may follow the last table entry
      repeat (5) begin
         @(negedge clk);
         assert (!rspValid) else failRun("extra response after the last table entry");
      end
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- mdUnit.f
logic/mdPkg.sv
logic/mdRequestStage.sv
logic/mdMultiplier.sv
logic/mdDivider.sv
logic/mdResponseStage.sv
logic/mdUnit.sv
tb/mdUnit_props.sv
tb/mdUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the mdUnit regression with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module mdUnitTb -f mdUnit.f -o mdUnitSim

# Keep the log even when the simulation exits with an error
status=0
./obj_dir/mdUnitSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log || [ "$status" -ne 0 ]; then
   echo "mdUnit simulation reported a failure"
   exit 1
fi
echo "mdUnit simulation finished cleanly"
